// ==== cpu8_core.f ====
common/cpu8_pkg.sv
common/cpu8_ctrl_if.sv
control/cycle_sequencer.sv
design/reg_file.sv
design/alu.sv
design/address_stack.sv
design/bus_latches.sv
design/cpu8_core.sv
test/tb_clock.sv
test/cpu8_core_tb.sv

// ==== test/cpu8_core_tb.sv ====
`timescale 1ns/10ps

module cpu8_core_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int CLOCKS_PER_OP  = 40;
  localparam int EXPECTED_INSTR = 900;  // All six tests together
  localparam int MARGIN_CLOCKS  = 1000;

  logic             clk;
  logic             por_rst;
  logic             test_rst;
  logic             dut_rst;
  cpu8_pkg::word_t  d_in;
  logic             ready;
  cpu8_pkg::word_t  d_out;
  logic             sync;
  cpu8_pkg::state_t state;

  cpu8_pkg::word_t  mem [16384];
  logic [13:0]      pc_w;        // Program build pointer
  cpu8_pkg::word_t  t1_byte;
  logic [31:0]      lfsr;
  logic [2:0]       ready_hist;  // Bit 0 is the newest
  logic             stall_en;
  int               wait_count;
  int               base_waits;
  cpu8_pkg::flags_t mflags;      // Expected flag register

  int got_port[$];
  int got_val[$];
  int exp_port[$];
  int exp_val[$];
  int trace_type[$];
  int trace_addr[$];

  cpu8_pkg::word_t opnd_a [16] = '{8'h7f, 8'h10, 8'h20, 8'h50, 8'hf0, 8'haa, 8'h01, 8'h40,
                                   8'h33, 8'hc8, 8'h05, 8'h00, 8'h0f, 8'h3c, 8'h80, 8'h9a};
  cpu8_pkg::word_t opnd_b [16] = '{8'h81, 8'h20, 8'h30, 8'h10, 8'h3c, 8'hff, 8'h80, 8'h40,
                                   8'h44, 8'h40, 8'h05, 8'h01, 8'hf0, 8'h3c, 8'h7f, 8'h9b};

  assign dut_rst = por_rst | test_rst;

  tb_clock u_clock (
    .clk (clk),
    .rst (por_rst)
  );

  cpu8_core DUT (
    .clk   (clk),
    .rst   (dut_rst),
    .d_in  (d_in),
    .ready (ready),
    .d_out (d_out),
    .sync  (sync),
    .state (state)
  );

  task automatic check(input int actual, input int expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    next_rand_bit = lfsr[31];
    lfsr = {lfsr[30:0], fb};
  endfunction

  // Returns {flags, result} for the eight ALU operations
  function automatic logic [11:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                            input logic [7:0] b, input logic [3:0] f);
    logic [8:0] wide;
    logic [3:0] nf;
    case (op)
      3'd0:       wide = a + b;
      3'd1:       wide = a + b + f[cpu8_pkg::FLAG_C];
      3'd2, 3'd7: wide = a - b;  // Bit 8 is the borrow
      3'd3:       wide = a - b - f[cpu8_pkg::FLAG_C];
      3'd4:       wide = {1'b0, a & b};
      3'd5:       wide = {1'b0, a ^ b};
      default:    wide = {1'b0, a | b};
    endcase
    nf[cpu8_pkg::FLAG_C] = wide[8];
    nf[cpu8_pkg::FLAG_Z] = (wide[7:0] == 8'h00);
    nf[cpu8_pkg::FLAG_S] = wide[7];
    nf[cpu8_pkg::FLAG_P] = ~^wide[7:0];
    return {nf, wide[7:0]};
  endfunction

  // INr and DCr keep carry
  function automatic logic [11:0] step_model(input logic [7:0] a, input logic down,
                                             input logic [3:0] f);
    logic [7:0] r;
    logic [3:0] nf;
    r  = down ? a - 8'd1 : a + 8'd1;
    nf = f;
    nf[cpu8_pkg::FLAG_Z] = (r == 8'h00);
    nf[cpu8_pkg::FLAG_S] = r[7];
    nf[cpu8_pkg::FLAG_P] = ~^r;
    return {nf, r};
  endfunction

  function automatic logic [11:0] rot_model(input logic [1:0] op, input logic [7:0] a,
                                            input logic [3:0] f);
    logic [7:0] r;
    logic       c;
    logic [3:0] nf;
    case (op)
      2'd0:    {c, r} = {a[7], a[6:0], a[7]};
      2'd1:    {r, c} = {a[0], a[7:1], a[0]};
      2'd2:    {c, r} = {a, f[cpu8_pkg::FLAG_C]};  // Nine-bit rotate through carry
      default: {r, c} = {f[cpu8_pkg::FLAG_C], a};
    endcase
    nf = f;
    nf[cpu8_pkg::FLAG_C] = c;
    return {nf, r};
  endfunction

  function automatic logic [7:0] out_op(input logic [4:0] port);
    return {2'b01, port, 1'b1};
  endfunction

  task automatic new_program();
    foreach (mem[i])
      mem[i] = 8'h00;  // HLT everywhere
    pc_w = '0;
    mflags = '0;
    exp_port.delete();
    exp_val.delete();
  endtask

  task automatic emit(input logic [7:0] b);
    mem[pc_w] = b;
    pc_w = pc_w + 1'b1;
  endtask

  task automatic emit_mvi(input logic [2:0] r, input logic [7:0] v);
    emit({2'b00, r, 3'b110});
    emit(v);
  endtask

  task automatic emit_addr(input logic [7:0] op, input logic [13:0] target);
    emit(op);
    emit(target[7:0]);
    emit({2'b00, target[13:8]});
  endtask

  task automatic emit_out(input int port, input logic [7:0] val);
    emit(out_op(port[4:0]));
    exp_port.push_back(port);
    exp_val.push_back(val);
  endtask

  // A ends as F0 when the flag is set and as 0F otherwise
  task automatic add_probe(input int flag, input logic flag_set);
    logic [13:0] target;
    emit_mvi(3'd0, 8'hf0);
    target = pc_w + 14'd5;
    emit_addr({3'b011, flag[1:0], 3'b000}, target);  // JTc
    emit_mvi(3'd0, 8'h0f);
    emit_out(9, flag_set ? 8'hf0 : 8'h0f);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 test_rst = 1'b1;
    repeat (10) @(posedge clk);
    got_port.delete();
    got_val.delete();
    trace_type.delete();
    trace_addr.delete();
    wait_count = 0;
    #1 test_rst = 1'b0;
  endtask

  task automatic run_program(input logic stall);
    stall_en = stall;
    apply_reset();
    do begin
      @(posedge clk);
      #1;
    end while (state != cpu8_pkg::STOPPED);
    check(got_val.size(), exp_val.size(), "number of OUT events");
    foreach (exp_val[i]) begin
      check(got_port[i], exp_port[i], "OUT port");
      check(got_val[i], exp_val[i], "OUT value");
    end
  endtask

  // Memory and I/O model that also drives ready
  always @(posedge clk) begin
    #5;
    if (dut_rst) begin
      d_in = '0;
      ready = 1'b1;
      ready_hist = 3'b111;
    end else begin
      if (state == cpu8_pkg::T3)
        check(ready_hist[2], 1, "ready three clocks before T3");
      if (state == cpu8_pkg::WAIT)
        wait_count++;
      if (state == cpu8_pkg::T1)
        t1_byte = d_out;
      if (state == cpu8_pkg::T2) begin
        trace_type.push_back(d_out[7:6]);
        if (d_out[7:6] == cpu8_pkg::PCC) begin
          trace_addr.push_back(d_out[5:0]);
          got_port.push_back(d_out[5:0]);
          got_val.push_back(t1_byte);  // Accumulator was out in T1
          d_in = '0;
        end else begin
          trace_addr.push_back({d_out[5:0], t1_byte});
          d_in = mem[{d_out[5:0], t1_byte}];
        end
      end
      if (stall_en)
        ready = next_rand_bit() | next_rand_bit();
      else
        ready = 1'b1;
      ready_hist = {ready_hist[1:0], ready};
    end
  end

  task automatic load_and_move_test();
    new_program();
    emit_mvi(3'd1, 8'h12);
    emit_mvi(3'd2, 8'h34);
    emit({2'b11, 3'd3, 3'd1});  // D <- B
    emit({2'b11, 3'd4, 3'd2});  // E <- C
    emit({2'b11, 3'd5, 3'd3});
    emit({2'b11, 3'd6, 3'd4});
    emit({2'b11, 3'd0, 3'd5});
    emit_out(8, 8'h12);
    emit({2'b11, 3'd0, 3'd6});
    emit_out(9, 8'h34);
    emit_mvi(3'd0, 8'h5a);
    emit_out(10, 8'h5a);
    run_program(1'b0);
  endtask

  task automatic build_alu_program();
    logic [11:0] m;
    logic [2:0]  src;
    new_program();
    for (int i = 0; i < 16; i++) begin
      src = 3'((i % 6) + 1);
      emit_mvi(3'd0, opnd_a[i]);
      if (i < 8) begin
        emit_mvi(src, opnd_b[i]);
        emit({2'b10, i[2:0], src});
      end else begin
        emit({2'b00, i[2:0], 3'b100});
        emit(opnd_b[i]);
      end
      m = alu_model(i[2:0], opnd_a[i], opnd_b[i], mflags);
      mflags = m[11:8];
      emit_out(8, (i[2:0] == 3'd7) ? opnd_a[i] : m[7:0]);  // CMP leaves A
      for (int f = 0; f < 4; f++)
        add_probe(f, mflags[f]);
    end
    emit_mvi(3'd2, 8'hff);
    emit(8'h10);  // INR C
    emit(8'hc2);
    m = step_model(8'hff, 1'b0, mflags);
    mflags = m[11:8];
    emit_out(8, m[7:0]);
    for (int f = 0; f < 4; f++)
      add_probe(f, mflags[f]);
    emit_mvi(3'd3, 8'h00);
    emit(8'h19);  // DCR D
    emit(8'hc3);
    m = step_model(8'h00, 1'b1, mflags);
    mflags = m[11:8];
    emit_out(8, m[7:0]);
    for (int f = 0; f < 4; f++)
      add_probe(f, mflags[f]);
  endtask

  task automatic alu_test();
    build_alu_program();
    run_program(1'b0);
    base_waits = wait_count;  // Startup WAIT with ready held high
  endtask

  task automatic rotate_test();
    logic [7:0]  vals [4];
    logic [11:0] m;
    vals = '{8'h81, 8'h81, 8'h40, 8'h01};
    new_program();
    for (int r = 0; r < 4; r++) begin
      emit_mvi(3'd0, vals[r]);
      emit({3'b000, r[1:0], 3'b010});
      m = rot_model(r[1:0], vals[r], mflags);
      mflags = m[11:8];
      emit_out(8, m[7:0]);
      add_probe(cpu8_pkg::FLAG_C, mflags[cpu8_pkg::FLAG_C]);
    end
    run_program(1'b0);
  endtask

  task automatic control_flow_test();
    logic [7:0] flow_vals [6];
    flow_vals = '{8'h01, 8'h02, 8'h03, 8'h40, 8'h41, 8'h05};  // OUT order along the path
    new_program();
    emit_addr(8'h44, 14'h0010);  // JMP
    emit_mvi(3'd0, 8'hee);
    emit(out_op(8));
    pc_w = 14'h0010;
    emit_addr(8'h46, 14'h0080);  // CAL
    emit_mvi(3'd0, 8'h03);
    emit(out_op(8));
    emit_mvi(3'd0, 8'h01);
    emit_mvi(3'd1, 8'h01);
    emit(8'hb9);                 // CMP B gives Z set and C clear
    emit_addr(8'h6a, 14'h0040);  // Taken CTZ
    emit_addr(8'h4a, 14'h0050);  // CFZ is not taken
    emit_addr(8'h40, 14'h0060);  // Taken JFC
    emit_mvi(3'd0, 8'hee);
    emit(out_op(8));
    pc_w = 14'h0040;
    emit_mvi(3'd0, 8'h40);
    emit(out_op(8));
    emit(8'h0b);                 // RFZ is not taken
    emit_mvi(3'd0, 8'h41);
    emit(out_op(8));
    emit(8'h2b);                 // Taken RTZ
    pc_w = 14'h0050;
    emit_mvi(3'd0, 8'hee);
    emit(out_op(8));
    pc_w = 14'h0060;
    emit_mvi(3'd0, 8'h05);
    emit(out_op(8));
    pc_w = 14'h0080;
    emit_mvi(3'd0, 8'h01);
    emit(out_op(8));
    emit_addr(8'h46, 14'h0130);
    emit(8'h07);                 // RET
    pc_w = 14'h0130;
    emit_mvi(3'd0, 8'h02);
    emit(out_op(8));
    emit(8'h07);
    foreach (flow_vals[i]) begin
      exp_port.push_back(8);
      exp_val.push_back(flow_vals[i]);
    end
    run_program(1'b0);
    check(trace_type[0], cpu8_pkg::PCI, "first T2 type");
    check(trace_addr[0], 14'h0000, "first fetch address");
    check(trace_type[1], cpu8_pkg::PCR, "jump low byte type");
    check(trace_addr[1], 14'h0001, "jump low byte address");
    check(trace_type[2], cpu8_pkg::PCR, "jump high byte type");
    check(trace_addr[2], 14'h0002, "jump high byte address");
    check(trace_type[3], cpu8_pkg::PCI, "fetch after jump type");
    check(trace_addr[3], 14'h0010, "fetch after jump address");
    check(trace_type[6], cpu8_pkg::PCI, "fetch after call type");
    check(trace_addr[6], 14'h0080, "fetch after call address");
    check(trace_type[9], cpu8_pkg::PCC, "first OUT cycle type");
    check(trace_addr[9], 8, "first OUT port in T2");
  endtask

  task automatic ready_stall_test();
    build_alu_program();
    run_program(1'b1);
    check(wait_count > base_waits, 1, "extra WAIT states under random ready");
    stall_en = 1'b0;
  endtask

  task automatic halt_test();
    new_program();
    emit_mvi(3'd0, 8'h77);
    emit_out(8, 8'h77);
    run_program(1'b0);
    repeat (20) begin
      @(posedge clk);
      #1;
      check(state, cpu8_pkg::STOPPED, "state after HLT");
      check(sync, 0, "sync after HLT");
    end
    apply_reset();
    check(state, cpu8_pkg::T1, "state after reset");
    check(sync, 1, "sync after reset");
    check(d_out, 8'h00, "T1 address byte after reset");
    @(posedge clk);
    #2;
    check(state, cpu8_pkg::T2, "second state after reset");
    check(d_out, 8'h00, "T2 byte after reset");
  endtask

  initial begin
    d_in       = '0;
    ready      = 1'b1;
    test_rst   = 1'b0;
    stall_en   = 1'b0;
    base_waits = 0;
    lfsr       = 32'hca46;
    ready_hist = 3'b111;
    wait (por_rst == 1'b0);
    load_and_move_test();
    alu_test();
    rotate_test();
    control_flow_test();
    ready_stall_test();
    halt_test();
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (CLOCKS_PER_OP * EXPECTED_INSTR + MARGIN_CLOCKS));
    $display("Timeout: the tests did not finish within the allowed time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 50;  // 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// ==== design/cpu8_core.sv ====
`timescale 1ns/10ps

module cpu8_core (
  input  logic             clk,
  input  logic             rst,
  input  cpu8_pkg::word_t  d_in,
  input  logic             ready,
  output cpu8_pkg::word_t  d_out,
  output logic             sync,
  output cpu8_pkg::state_t state
);

  cpu8_pkg::word_t  instr;
  cpu8_pkg::word_t  pc_byte;
  cpu8_pkg::word_t  rd_data;
  cpu8_pkg::word_t  acc;
  cpu8_pkg::word_t  alu_result;
  cpu8_pkg::word_t  tmp_a;
  cpu8_pkg::word_t  tmp_b;
  cpu8_pkg::flags_t flags;

  cpu8_ctrl_if ctrl ();

  cycle_sequencer u_sequencer (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .instr (instr),
    .flags (flags),
    .ctrl  (ctrl.sequencer),
    .state (state),
    .sync  (sync)
  );

  // The internal bus drives the pins directly
  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl.regs),
    .bus_val (d_out),
    .rd_data (rd_data),
    .acc     (acc)
  );

  alu u_alu (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl.alu),
    .a      (tmp_a),
    .b      (tmp_b),
    .result (alu_result),
    .flags  (flags)
  );

  address_stack u_stack (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl.stack),
    .bus_val (d_out),
    .pc_byte (pc_byte)
  );

  bus_latches u_latches (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl.latches),
    .d_in       (d_in),
    .pc_byte    (pc_byte),
    .rd_data    (rd_data),
    .alu_result (alu_result),
    .acc        (acc),
    .tmp_a      (tmp_a),
    .tmp_b      (tmp_b),
    .instr      (instr),
    .bus_val    (d_out)
  );

endmodule

// ==== design/bus_latches.sv ====
`timescale 1ns/10ps

module bus_latches (
  input  logic            clk,
  input  logic            rst,
  cpu8_ctrl_if.latches    ctrl,
  input  cpu8_pkg::word_t d_in,
  input  cpu8_pkg::word_t pc_byte,
  input  cpu8_pkg::word_t rd_data,
  input  cpu8_pkg::word_t alu_result,
  input  cpu8_pkg::word_t acc,
  output cpu8_pkg::word_t tmp_a,
  output cpu8_pkg::word_t tmp_b,
  output cpu8_pkg::word_t instr,
  output cpu8_pkg::word_t bus_val
);

  cpu8_pkg::word_t ir;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir    <= '0;
      tmp_a <= '0;
      tmp_b <= '0;
    end else begin
      if (ctrl.ir_we)
        ir <= d_in;
      // A dual load is an operand fetch, A then takes the accumulator
      if (ctrl.tmp_a_we)
        tmp_a <= ctrl.tmp_b_we ? acc : bus_val;
      if (ctrl.tmp_b_we)
        tmp_b <= bus_val;
    end
  end

  // Bypass so the fetch T3 decodes the incoming opcode
  assign instr = ctrl.ir_we ? d_in : ir;

  always_comb begin
    case (ctrl.bus_src)
      cpu8_pkg::STACK: begin
        if (ctrl.cycle_type == cpu8_pkg::PCC)
          bus_val = {cpu8_pkg::PCC, 1'b0, ir[5:1]};  // Port number for OUT
        else
          bus_val = pc_byte;
      end
      cpu8_pkg::REGS:  bus_val = rd_data;
      cpu8_pkg::ALU:   bus_val = alu_result;
      cpu8_pkg::TMP_A: bus_val = tmp_a;
      cpu8_pkg::TMP_B: bus_val = tmp_b;
      cpu8_pkg::DIN:   bus_val = d_in;
      default:         bus_val = '0;
    endcase
  end

endmodule

// ==== design/address_stack.sv ====
`timescale 1ns/10ps

module address_stack (
  input  logic            clk,
  input  logic            rst,
  cpu8_ctrl_if.stack      ctrl,
  input  cpu8_pkg::word_t bus_val,
  output cpu8_pkg::word_t pc_byte
);

  cpu8_pkg::addr_t entries [cpu8_pkg::STACK_DEPTH];
  cpu8_pkg::sp_t   sp;
  cpu8_pkg::addr_t pc;

  assign pc = entries[sp];  // Top entry is the live PC

  // Saturates at both ends
  always_ff @(posedge clk) begin
    if (rst)
      sp <= '0;
    else if (ctrl.sp_push && (sp != cpu8_pkg::sp_t'(cpu8_pkg::STACK_DEPTH - 1)))
      sp <= sp + 1'b1;
    else if (ctrl.sp_pop && (sp != '0))
      sp <= sp - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu8_pkg::STACK_DEPTH; i++)
        entries[i] <= '0;
    end else if (ctrl.stack_we_low) begin
      entries[sp][7:0] <= bus_val;
    end else if (ctrl.stack_we_high) begin
      entries[sp][13:8] <= bus_val[5:0];
    end else if (ctrl.pc_inc) begin
      entries[sp] <= pc + 1'b1;
    end
  end

  assign pc_byte = ctrl.stack_re_low ? pc[7:0] : {ctrl.cycle_type, pc[13:8]};

endmodule

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu (
  input  logic             clk,
  input  logic             rst,
  cpu8_ctrl_if.alu         ctrl,
  input  cpu8_pkg::word_t  a,
  input  cpu8_pkg::word_t  b,
  output cpu8_pkg::word_t  result,
  output cpu8_pkg::flags_t flags
);

  cpu8_pkg::word_t  operand;
  cpu8_pkg::word_t  arith;
  cpu8_pkg::word_t  rot_res;
  cpu8_pkg::flags_t flags_d;
  logic             carry_out;
  logic             rot_carry;

  assign operand = ctrl.alu_go ? b : 8'd1;  // INr/DCr step by one

  always_comb begin
    carry_out = 1'b0;
    case (ctrl.alu_op)
      cpu8_pkg::ADD: {carry_out, arith} = {1'b0, a} + {1'b0, operand};
      cpu8_pkg::ADC: {carry_out, arith} = {1'b0, a} + {1'b0, operand} + flags[cpu8_pkg::FLAG_C];
      cpu8_pkg::SBB: {carry_out, arith} = {1'b0, a} - {1'b0, operand} - flags[cpu8_pkg::FLAG_C];
      cpu8_pkg::AND: arith = a & operand;
      cpu8_pkg::XOR: arith = a ^ operand;
      cpu8_pkg::OR:  arith = a | operand;
      default:       {carry_out, arith} = {1'b0, a} - {1'b0, operand};  // SUB, CMP
    endcase
  end

  always_comb begin
    case (ctrl.rot_op)
      cpu8_pkg::RLC: rot_res = {a[6:0], a[7]};
      cpu8_pkg::RRC: rot_res = {a[0], a[7:1]};
      cpu8_pkg::RAL: rot_res = {a[6:0], flags[cpu8_pkg::FLAG_C]};
      default:       rot_res = {flags[cpu8_pkg::FLAG_C], a[7:1]};  // RAR
    endcase
  end

  assign rot_carry = ctrl.rot_op[0] ? a[0] : a[7];  // Odd codes rotate right
  assign result    = ctrl.alu_is_rot ? rot_res : arith;

  always_comb begin
    flags_d = flags;
    if (ctrl.alu_is_rot) begin
      flags_d[cpu8_pkg::FLAG_C] = rot_carry;
    end else begin
      if (ctrl.alu_go)
        flags_d[cpu8_pkg::FLAG_C] = carry_out;  // Logic ops give zero here
      flags_d[cpu8_pkg::FLAG_Z] = (arith == '0);
      flags_d[cpu8_pkg::FLAG_S] = arith[7];
      flags_d[cpu8_pkg::FLAG_P] = ~^arith;  // Even parity
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      flags <= '0;
    else if (ctrl.flag_we)
      flags <= flags_d;
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic            clk,
  input  logic            rst,
  cpu8_ctrl_if.regs       ctrl,
  input  cpu8_pkg::word_t bus_val,
  output cpu8_pkg::word_t rd_data,
  output cpu8_pkg::word_t acc
);

  cpu8_pkg::word_t regs [cpu8_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu8_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end else if (ctrl.reg_we && (ctrl.reg_sel < cpu8_pkg::NUM_REGS)) begin
      regs[ctrl.reg_sel] <= bus_val;
    end
  end

  // Code 7 names memory and reads as zero
  assign rd_data = (ctrl.reg_sel < cpu8_pkg::NUM_REGS) ? regs[ctrl.reg_sel] : '0;
  assign acc     = regs[cpu8_pkg::REG_A];

endmodule

// ==== control/cycle_sequencer.sv ====
`timescale 1ns/10ps

module cycle_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              ready,
  input  cpu8_pkg::word_t   instr,
  input  cpu8_pkg::flags_t  flags,
  cpu8_ctrl_if.sequencer    ctrl,
  output cpu8_pkg::state_t  state,
  output logic              sync
);

  logic               ready_meta;
  logic               ready_s;
  cpu8_pkg::cyc_t     cycle;
  cpu8_pkg::state_t   next_state;
  cpu8_pkg::cyc_t     next_cycle;
  cpu8_pkg::reg_sel_t ddd;
  cpu8_pkg::reg_sel_t sss;
  cpu8_pkg::alu_op_t  op_field;
  logic               is_hlt, is_mov, is_step, is_rot, is_alu_r, is_alu_i;
  logic               is_lri, is_out, is_jmp, is_cal, is_ret;
  logic               cond_flag;
  logic               taken;

  // Two-flop synchronizer on ready
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_meta <= 1'b0;
      ready_s    <= 1'b0;
    end else begin
      ready_meta <= ready;
      ready_s    <= ready_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpu8_pkg::T1;
      cycle <= cpu8_pkg::CYC1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

  assign sync = (state == cpu8_pkg::T1) || (state == cpu8_pkg::T2);

  // Opcode fields and classes
  assign ddd      = instr[5:3];
  assign sss      = instr[2:0];
  assign op_field = cpu8_pkg::alu_op_t'(instr[5:3]);

  assign is_hlt   = (instr[7:1] == 7'd0) || (instr == 8'hff);
  assign is_mov   = (instr[7:6] == 2'b11) && (ddd != cpu8_pkg::REG_M) && (sss != cpu8_pkg::REG_M);
  assign is_step  = (instr[7:6] == 2'b00) && (instr[2:1] == 2'b00)
                    && (ddd != cpu8_pkg::REG_A) && (ddd != cpu8_pkg::REG_M);  // INr, DCr
  assign is_rot   = (instr[7:5] == 3'b000) && (sss == 3'b010);
  assign is_alu_r = (instr[7:6] == 2'b10) && (sss != cpu8_pkg::REG_M);
  assign is_alu_i = (instr[7:6] == 2'b00) && (sss == 3'b100);
  assign is_lri   = (instr[7:6] == 2'b00) && (sss == 3'b110) && (ddd != cpu8_pkg::REG_M);
  assign is_out   = (instr[7:6] == 2'b01) && instr[0] && (instr[5:4] != 2'b00);
  assign is_jmp   = (instr[7:6] == 2'b01) && (instr[1:0] == 2'b00);
  assign is_cal   = (instr[7:6] == 2'b01) && (instr[1:0] == 2'b10);
  assign is_ret   = (instr[7:6] == 2'b00) && (instr[1:0] == 2'b11);

  always_comb begin
    case (instr[4:3])
      2'b00:   cond_flag = flags[cpu8_pkg::FLAG_C];
      2'b01:   cond_flag = flags[cpu8_pkg::FLAG_Z];
      2'b10:   cond_flag = flags[cpu8_pkg::FLAG_S];
      default: cond_flag = flags[cpu8_pkg::FLAG_P];
    endcase
  end

  // Bit 2 marks the unconditional form, bit 5 picks true or false test
  assign taken = instr[2] || (instr[5] == cond_flag);

  always_comb begin
    next_state         = state;
    next_cycle         = cycle;
    ctrl.bus_src       = cpu8_pkg::NONE;
    ctrl.reg_we        = 1'b0;
    ctrl.reg_sel       = sss;
    ctrl.tmp_a_we      = 1'b0;
    ctrl.tmp_b_we      = 1'b0;
    ctrl.ir_we         = 1'b0;
    ctrl.alu_go        = 1'b0;
    ctrl.alu_is_rot    = 1'b0;
    ctrl.alu_op        = op_field;
    ctrl.rot_op        = cpu8_pkg::rot_op_t'(instr[4:3]);
    ctrl.flag_we       = 1'b0;
    ctrl.stack_re_low  = 1'b0;
    ctrl.stack_we_low  = 1'b0;
    ctrl.stack_we_high = 1'b0;
    ctrl.sp_push       = 1'b0;
    ctrl.sp_pop        = 1'b0;
    ctrl.pc_inc        = 1'b0;
    ctrl.cycle_type    = cpu8_pkg::PCI;

    case (state)
      cpu8_pkg::T1: begin
        next_state = cpu8_pkg::T2;
        if (cycle == cpu8_pkg::CYC2 && is_out) begin
          ctrl.bus_src = cpu8_pkg::REGS;  // Accumulator goes out as data
          ctrl.reg_sel = cpu8_pkg::REG_A;
        end else begin
          ctrl.bus_src      = cpu8_pkg::STACK;
          ctrl.stack_re_low = 1'b1;
        end
      end
      cpu8_pkg::T2: begin
        next_state   = ready_s ? cpu8_pkg::T3 : cpu8_pkg::WAIT;
        ctrl.bus_src = cpu8_pkg::STACK;
        if (cycle == cpu8_pkg::CYC1) begin
          ctrl.pc_inc = 1'b1;
        end else if (is_out) begin
          ctrl.cycle_type = cpu8_pkg::PCC;
        end else begin
          ctrl.cycle_type = cpu8_pkg::PCR;
          ctrl.pc_inc     = 1'b1;
        end
      end
      cpu8_pkg::WAIT:
        next_state = ready_s ? cpu8_pkg::T3 : cpu8_pkg::WAIT;
      cpu8_pkg::T3: begin
        next_state = cpu8_pkg::T1;
        case (cycle)
          cpu8_pkg::CYC1: begin
            ctrl.ir_we = 1'b1;  // instr already shows the new opcode here
            if (is_hlt)
              next_state = cpu8_pkg::STOPPED;
            else if (is_lri || is_alu_i || is_out || is_jmp || is_cal)
              next_cycle = cpu8_pkg::CYC2;
            else if (is_mov || is_step || is_rot || is_alu_r || (is_ret && taken))
              next_state = cpu8_pkg::T4;
          end
          cpu8_pkg::CYC2: begin
            ctrl.bus_src  = cpu8_pkg::DIN;
            ctrl.tmp_a_we = is_alu_i;
            ctrl.tmp_b_we = !is_out;  // Immediate or low target byte
            if (is_out)
              next_cycle = cpu8_pkg::CYC1;
            else if (is_jmp || is_cal)
              next_cycle = cpu8_pkg::CYC3;
            else
              next_state = cpu8_pkg::T4;
          end
          default: begin
            // High target byte
            ctrl.bus_src  = cpu8_pkg::DIN;
            ctrl.tmp_a_we = 1'b1;
            if (taken) begin
              next_state   = cpu8_pkg::T4;
              ctrl.sp_push = is_cal;  // Return address stays in the old entry
            end else begin
              next_cycle = cpu8_pkg::CYC1;
            end
          end
        endcase
      end
      cpu8_pkg::T4: begin
        next_state = cpu8_pkg::T5;
        if (cycle == cpu8_pkg::CYC1) begin
          ctrl.bus_src  = cpu8_pkg::REGS;
          ctrl.reg_sel  = is_step ? ddd : (is_rot ? cpu8_pkg::REG_A : sss);
          ctrl.tmp_a_we = is_step || is_rot || is_alu_r;
          ctrl.tmp_b_we = is_mov || is_alu_r;
          ctrl.sp_pop   = is_ret;
        end else if (cycle == cpu8_pkg::CYC3) begin
          ctrl.bus_src       = cpu8_pkg::TMP_A;
          ctrl.stack_we_high = 1'b1;
        end
      end
      cpu8_pkg::T5: begin
        next_state = cpu8_pkg::T1;
        next_cycle = cpu8_pkg::CYC1;
        if (cycle == cpu8_pkg::CYC3) begin
          ctrl.bus_src      = cpu8_pkg::TMP_B;
          ctrl.stack_we_low = 1'b1;
        end else if (is_mov || is_lri) begin
          ctrl.bus_src = cpu8_pkg::TMP_B;
          ctrl.reg_sel = ddd;
          ctrl.reg_we  = 1'b1;
        end else if (!is_ret) begin
          // ALU, step and rotate write back
          ctrl.bus_src    = cpu8_pkg::ALU;
          ctrl.flag_we    = 1'b1;
          ctrl.alu_go     = is_alu_r || is_alu_i;
          ctrl.alu_is_rot = is_rot;
          ctrl.alu_op     = is_step ? (instr[0] ? cpu8_pkg::SUB : cpu8_pkg::ADD) : op_field;
          ctrl.reg_sel    = is_step ? ddd : cpu8_pkg::REG_A;
          ctrl.reg_we     = is_step || is_rot || (op_field != cpu8_pkg::CMP);
        end
      end
      default:
        next_state = state;  // STOPPED holds until reset
    endcase
  end

endmodule

// ==== common/cpu8_ctrl_if.sv ====
`timescale 1ns/10ps

interface cpu8_ctrl_if;

  cpu8_pkg::bus_src_t    bus_src;
  logic                  reg_we;
  cpu8_pkg::reg_sel_t    reg_sel;
  logic                  tmp_a_we;
  logic                  tmp_b_we;
  logic                  ir_we;
  logic                  alu_go;      // Low selects the step by one
  logic                  alu_is_rot;
  cpu8_pkg::alu_op_t     alu_op;
  cpu8_pkg::rot_op_t     rot_op;
  logic                  flag_we;
  logic                  stack_re_low;
  logic                  stack_we_low;
  logic                  stack_we_high;
  logic                  sp_push;
  logic                  sp_pop;
  logic                  pc_inc;
  cpu8_pkg::cycle_type_t cycle_type;

  modport sequencer (
    output bus_src, reg_we, reg_sel, tmp_a_we, tmp_b_we, ir_we,
    output alu_go, alu_is_rot, alu_op, rot_op, flag_we,
    output stack_re_low, stack_we_low, stack_we_high, sp_push, sp_pop, pc_inc,
    output cycle_type
  );
  modport regs (input reg_we, reg_sel);
  modport alu (input alu_go, alu_is_rot, alu_op, rot_op, flag_we);
  modport stack (
    input stack_re_low, stack_we_low, stack_we_high, sp_push, sp_pop, pc_inc, cycle_type
  );
  modport latches (input bus_src, tmp_a_we, tmp_b_we, ir_we, cycle_type);

endinterface

// ==== common/cpu8_pkg.sv ====
package cpu8_pkg;

  // Data and address widths
  typedef logic [7:0]  word_t;
  typedef logic [13:0] addr_t;
  typedef logic [2:0]  sp_t;
  typedef logic [2:0]  reg_sel_t;
  typedef logic [3:0]  flags_t;

  // Flag bit positions follow the condition field order
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_S = 2;
  localparam int FLAG_P = 3;

  localparam int STACK_DEPTH = 8;
  localparam int NUM_REGS    = 7;

  // Register field codes with B..L following A in order
  localparam reg_sel_t REG_A = 3'd0;
  localparam reg_sel_t REG_M = 3'd7;  // Memory operand, not supported

  typedef enum logic [2:0] {
    T1,
    T2,
    T3,
    T4,
    T5,
    WAIT,
    STOPPED
  } state_t;

  typedef enum logic [1:0] {
    CYC1,
    CYC2,
    CYC3
  } cyc_t;

  // Bits 7:6 of the T2 byte
  typedef enum logic [1:0] {
    PCI = 2'b00,  // Instruction fetch
    PCR = 2'b10,  // Memory read
    PCC = 2'b01   // I/O command
  } cycle_type_t;

  // Same order as instruction bits 5:3
  typedef enum logic [2:0] {
    ADD,
    ADC,
    SUB,
    SBB,
    AND,
    XOR,
    OR,
    CMP
  } alu_op_t;

  typedef enum logic [1:0] {
    RLC,
    RRC,
    RAL,
    RAR
  } rot_op_t;

  typedef enum logic [2:0] {
    NONE,
    STACK,
    REGS,
    ALU,
    TMP_A,
    TMP_B,
    DIN
  } bus_src_t;

endpackage
